/* mipsSlice.f */
rtl/cpuTypesPkg.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/apbRegs.sv
rtl/mipsSlice.sv
sim/mipsSliceTb.sv

/* rtl/apbRegs.sv */
// APB slave owning the PC and halt state, issuing instructions and serving register reads.
`timescale 1ns/1ps
`default_nettype none

module apbRegs import cpuTypesPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  apbAddrT paddr,
    input  wordT    pwdata,
    input  wordT    nextPc,
    input  logic    haltSet,
    input  wordT    dbgData,
    output wordT    prdata,
    output logic    pready,
    output logic    pslverr,
    output wordT    instr,
    output logic    issue,
    output wordT    pc,
    output regBitsT dbgAddr
);

    logic access;
    logic halted;
    logic hitInstr;
    logic hitPc;
    logic hitStatus;
    logic hitReg;
    logic mapped;
    logic readOnly;
    logic error;

    assign access    = psel && penable;
    assign hitInstr  = (paddr == addrInstr);
    assign hitPc     = (paddr == addrPc);
    assign hitStatus = (paddr == addrStatus);
    assign hitReg    = ((paddr & 8'h83) == addrRegBase);
    assign mapped    = hitInstr || hitPc || hitStatus || hitReg;
    assign readOnly  = hitStatus || hitReg;

    assign error = !mapped || (pwrite && readOnly) || (pwrite && hitInstr && halted);

    assign issue   = access && pwrite && hitInstr && !halted;
    assign instr   = (access && hitInstr) ? pwdata : '0;
    assign dbgAddr = paddr[6:2];

    // Zero wait states on every access.
    assign pready  = 1'b1;
    assign pslverr = access && error;

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hitPc) begin
                prdata = pc;
            end else if (hitStatus) begin
                prdata = {31'd0, halted};
            end else if (hitReg) begin
                prdata = dbgData;
            end
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (issue) begin
            pc     <= nextPc;
            halted <= haltSet;
        end else if (access && pwrite && hitPc) begin
            pc <= pwdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
// Instruction decoder turning opcode and function fields into datapath controls.
`timescale 1ns/1ps
`default_nettype none

module controlUnit import cpuTypesPkg::*; (
    input  opcodeT opcode,
    input  functT  funct,
    output logic   regDst,
    output logic   regWr,
    output logic   memWr,
    output logic   memRd,
    output logic   memToReg,
    output logic   aluSrc,
    output logic   extOp,
    output logic   shiftUp,
    output logic   wrLinkReg,
    output logic   halt,
    output pcSrcT  pcSrc,
    output aluOpT  aluOp
);

    // ALU groups. The R-type group defers to the function field.
    localparam logic [2:0] grpSub   = 3'd0;
    localparam logic [2:0] grpOr    = 3'd1;
    localparam logic [2:0] grpAnd   = 3'd2;
    localparam logic [2:0] grpXor   = 3'd3;
    localparam logic [2:0] grpRtype = 3'd4;
    localparam logic [2:0] grpAdd   = 3'd5;
    localparam logic [2:0] grpSlt   = 3'd6;
    localparam logic [2:0] grpSltu  = 3'd7;

    logic [2:0] aluGroup;

    always_comb begin
        aluGroup  = grpSub;
        regDst    = 1'b0;
        regWr     = 1'b0;
        memWr     = 1'b0;
        memRd     = 1'b0;
        memToReg  = 1'b0;
        aluSrc    = 1'b0;
        extOp     = 1'b0;
        shiftUp   = 1'b0;
        wrLinkReg = 1'b0;
        halt      = 1'b0;
        pcSrc     = pcNext;
        case (opcode)
            RTYPE: begin
                aluGroup = grpRtype;
                if (funct == JR) begin
                    pcSrc = pcJumpR;
                end else begin
                    regDst = 1'b1;
                    regWr  = 1'b1;
                end
            end
            J: begin
                pcSrc = pcJump;
            end
            JAL: begin
                wrLinkReg = 1'b1;
                regWr     = 1'b1;
                pcSrc     = pcJump;
            end
            BEQ: begin
                pcSrc = pcBreq;
            end
            BNE: begin
                pcSrc = pcBrne;
            end
            ADDI, ADDIU: begin
                aluGroup = grpAdd;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                extOp    = 1'b1;
            end
            SLTI: begin
                aluGroup = grpSlt;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                extOp    = 1'b1;
            end
            SLTIU: begin
                aluGroup = grpSltu;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                extOp    = 1'b1;
            end
            ANDI: begin
                aluGroup = grpAnd;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
            end
            ORI: begin
                aluGroup = grpOr;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
            end
            XORI: begin
                aluGroup = grpXor;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
            end
            LUI: begin
                // rs is zero in LUI, so OR passes the shifted immediate.
                aluGroup = grpOr;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                shiftUp  = 1'b1;
            end
            LW: begin
                aluGroup = grpAdd;
                memRd    = 1'b1;
                regWr    = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                extOp    = 1'b1;
            end
            SW: begin
                aluGroup = grpAdd;
                memWr    = 1'b1;
                aluSrc   = 1'b1;
                extOp    = 1'b1;
            end
            HALT: begin
                halt  = 1'b1;
                pcSrc = pcKeep;
            end
            default: begin
                // Unknown opcodes fall through as no-ops.
            end
        endcase
    end

    always_comb begin
        aluOp = aluSub;
        case (aluGroup)
            grpSub:  aluOp = aluSub;
            grpOr:   aluOp = aluOr;
            grpAnd:  aluOp = aluAnd;
            grpXor:  aluOp = aluXor;
            grpAdd:  aluOp = aluAdd;
            grpSlt:  aluOp = aluSlt;
            grpSltu: aluOp = aluSltu;
            grpRtype: begin
                case (funct)
                    SLLV:       aluOp = aluSll;
                    SRLV:       aluOp = aluSrl;
                    ADD, ADDU:  aluOp = aluAdd;
                    SUB, SUBU:  aluOp = aluSub;
                    AND:        aluOp = aluAnd;
                    OR:         aluOp = aluOr;
                    XOR:        aluOp = aluXor;
                    NOR:        aluOp = aluNor;
                    SLT:        aluOp = aluSlt;
                    SLTU:       aluOp = aluSltu;
                    default:    aluOp = aluSub;
                endcase
            end
            default: aluOp = aluSub;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cpuTypesPkg.sv */
// Shared types, instruction encodings and APB register map for the MIPS execution slice.
`default_nettype none

package cpuTypesPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regBitsT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [3:0]  aluOpT;
    typedef logic [2:0]  pcSrcT;
    typedef logic [7:0]  apbAddrT;

    // Opcode field encodings.
    localparam opcodeT RTYPE = 6'b000000;
    localparam opcodeT J     = 6'b000010;
    localparam opcodeT JAL   = 6'b000011;
    localparam opcodeT BEQ   = 6'b000100;
    localparam opcodeT BNE   = 6'b000101;
    localparam opcodeT ADDI  = 6'b001000;
    localparam opcodeT ADDIU = 6'b001001;
    localparam opcodeT SLTI  = 6'b001010;
    localparam opcodeT SLTIU = 6'b001011;
    localparam opcodeT ANDI  = 6'b001100;
    localparam opcodeT ORI   = 6'b001101;
    localparam opcodeT XORI  = 6'b001110;
    localparam opcodeT LUI   = 6'b001111;
    localparam opcodeT LW    = 6'b100011;
    localparam opcodeT SW    = 6'b101011;
    localparam opcodeT HALT  = 6'b111111;

    // Function field encodings for R-type instructions.
    localparam functT SLLV = 6'b000100;
    localparam functT SRLV = 6'b000110;
    localparam functT JR   = 6'b001000;
    localparam functT ADD  = 6'b100000;
    localparam functT ADDU = 6'b100001;
    localparam functT SUB  = 6'b100010;
    localparam functT SUBU = 6'b100011;
    localparam functT AND  = 6'b100100;
    localparam functT OR   = 6'b100101;
    localparam functT XOR  = 6'b100110;
    localparam functT NOR  = 6'b100111;
    localparam functT SLT  = 6'b101010;
    localparam functT SLTU = 6'b101011;

    // ALU operations.
    localparam aluOpT aluSll  = 4'd0;
    localparam aluOpT aluSrl  = 4'd1;
    localparam aluOpT aluAdd  = 4'd2;
    localparam aluOpT aluSub  = 4'd3;
    localparam aluOpT aluAnd  = 4'd4;
    localparam aluOpT aluOr   = 4'd5;
    localparam aluOpT aluXor  = 4'd6;
    localparam aluOpT aluNor  = 4'd7;
    localparam aluOpT aluSlt  = 4'd8;
    localparam aluOpT aluSltu = 4'd9;

    // Next program counter sources.
    localparam pcSrcT pcNext  = 3'd0;
    localparam pcSrcT pcBreq  = 3'd1;
    localparam pcSrcT pcBrne  = 3'd2;
    localparam pcSrcT pcJump  = 3'd3;
    localparam pcSrcT pcJumpR = 3'd4;
    localparam pcSrcT pcKeep  = 3'd5;

    // APB register map. Register n of the file reads at addrRegBase + 4*n.
    localparam apbAddrT addrInstr   = 8'h00;
    localparam apbAddrT addrPc      = 8'h04;
    localparam apbAddrT addrStatus  = 8'h08;
    localparam apbAddrT addrRegBase = 8'h80;

    localparam int dataMemWords    = 16;
    localparam int dataMemAddrBits = $clog2(dataMemWords);

endpackage

`default_nettype wire

/* rtl/executeUnit.sv */
// Execute stage with ALU, data memory, write-back selection and next-PC logic.
`timescale 1ns/1ps
`default_nettype none

module executeUnit import cpuTypesPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    issue,
    input  logic    regDst,
    input  logic    regWr,
    input  logic    memWr,
    input  logic    memRd,
    input  logic    memToReg,
    input  logic    aluSrc,
    input  logic    extOp,
    input  logic    shiftUp,
    input  logic    wrLinkReg,
    input  logic    halt,
    input  pcSrcT   pcSrc,
    input  aluOpT   aluOp,
    input  wordT    instr,
    input  wordT    pc,
    input  wordT    rsData,
    input  wordT    rtData,
    output logic    regWrEn,
    output regBitsT regWrAddr,
    output wordT    regWrData,
    output wordT    nextPc,
    output logic    haltSet
);

    wordT dataMem [dataMemWords];

    logic [15:0]                imm;
    wordT                       immExt;
    wordT                       opB;
    wordT                       aluResult;
    wordT                       memRdData;
    wordT                       pcPlus4;
    wordT                       branchTarget;
    logic [dataMemAddrBits-1:0] memIdx;

    assign imm    = instr[15:0];
    assign immExt = extOp ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    assign opB    = !aluSrc ? rtData : (shiftUp ? {imm, 16'h0000} : immExt);

    always_comb begin
        case (aluOp)
            aluSll:  aluResult = opB << rsData[4:0];
            aluSrl:  aluResult = opB >> rsData[4:0];
            aluAdd:  aluResult = rsData + opB;
            aluSub:  aluResult = rsData - opB;
            aluAnd:  aluResult = rsData & opB;
            aluOr:   aluResult = rsData | opB;
            aluXor:  aluResult = rsData ^ opB;
            aluNor:  aluResult = ~(rsData | opB);
            aluSlt:  aluResult = {31'd0, $signed(rsData) < $signed(opB)};
            aluSltu: aluResult = {31'd0, rsData < opB};
            default: aluResult = '0;
        endcase
    end

    // Word addressed; upper address bits wrap around the small memory.
    assign memIdx = aluResult[dataMemAddrBits+1:2];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < dataMemWords; i++) begin
                dataMem[i] <= '0;
            end
        end else if (issue && memWr) begin
            dataMem[memIdx] <= rtData;
        end
    end

    assign memRdData = memRd ? dataMem[memIdx] : '0;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

    always_comb begin
        if (wrLinkReg) begin
            regWrAddr = 5'd31;
        end else if (regDst) begin
            regWrAddr = instr[15:11];
        end else begin
            regWrAddr = instr[20:16];
        end
    end

    always_comb begin
        if (wrLinkReg) begin
            regWrData = pcPlus4;
        end else if (memToReg) begin
            regWrData = memRdData;
        end else begin
            regWrData = aluResult;
        end
    end

    always_comb begin
        case (pcSrc)
            pcNext:  nextPc = pcPlus4;
            pcBreq:  nextPc = (aluResult == '0) ? branchTarget : pcPlus4;
            pcBrne:  nextPc = (aluResult != '0) ? branchTarget : pcPlus4;
            pcJump:  nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            pcJumpR: nextPc = rsData;
            pcKeep:  nextPc = pc;
            default: nextPc = pcPlus4;
        endcase
    end

    assign regWrEn = issue && regWr;
    assign haltSet = halt;

endmodule

`default_nettype wire

/* rtl/mipsSlice.sv */
// Top level of the APB-driven single-issue MIPS execution slice.
`timescale 1ns/1ps
`default_nettype none

module mipsSlice import cpuTypesPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  apbAddrT paddr,
    input  wordT    pwdata,
    output wordT    prdata,
    output logic    pready,
    output logic    pslverr
);

    wordT    instr;
    wordT    pc;
    wordT    nextPc;
    wordT    rsData;
    wordT    rtData;
    wordT    dbgData;
    wordT    regWrData;
    regBitsT dbgAddr;
    regBitsT regWrAddr;
    logic    issue;
    logic    regWrEn;
    logic    haltSet;
    logic    regDst;
    logic    regWr;
    logic    memWr;
    logic    memRd;
    logic    memToReg;
    logic    aluSrc;
    logic    extOp;
    logic    shiftUp;
    logic    wrLinkReg;
    logic    halt;
    pcSrcT   pcSrc;
    aluOpT   aluOp;

    apbRegs apbRegsInst (
        .CLK(CLK), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .nextPc(nextPc), .haltSet(haltSet), .dbgData(dbgData),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .instr(instr), .issue(issue), .pc(pc), .dbgAddr(dbgAddr)
    );

    controlUnit controlUnitInst (
        .opcode(instr[31:26]), .funct(instr[5:0]),
        .regDst(regDst), .regWr(regWr), .memWr(memWr), .memRd(memRd),
        .memToReg(memToReg), .aluSrc(aluSrc), .extOp(extOp), .shiftUp(shiftUp),
        .wrLinkReg(wrLinkReg), .halt(halt), .pcSrc(pcSrc), .aluOp(aluOp)
    );

    registerFile registerFileInst (
        .CLK(CLK), .rstN(rstN),
        .rsAddr(instr[25:21]), .rtAddr(instr[20:16]), .dbgAddr(dbgAddr),
        .wrAddr(regWrAddr), .wrEn(regWrEn), .wrData(regWrData),
        .rsData(rsData), .rtData(rtData), .dbgData(dbgData)
    );

    executeUnit executeUnitInst (
        .CLK(CLK), .rstN(rstN), .issue(issue),
        .regDst(regDst), .regWr(regWr), .memWr(memWr), .memRd(memRd),
        .memToReg(memToReg), .aluSrc(aluSrc), .extOp(extOp), .shiftUp(shiftUp),
        .wrLinkReg(wrLinkReg), .halt(halt), .pcSrc(pcSrc), .aluOp(aluOp),
        .instr(instr), .pc(pc), .rsData(rsData), .rtData(rtData),
        .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
        .nextPc(nextPc), .haltSet(haltSet)
    );

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
// 32-entry register file with two operand read ports, a debug read port and one write port.
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuTypesPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  regBitsT rsAddr,
    input  regBitsT rtAddr,
    input  regBitsT dbgAddr,
    input  regBitsT wrAddr,
    input  logic    wrEn,
    input  wordT    wrData,
    output wordT    rsData,
    output wordT    rtData,
    output wordT    dbgData
);

    wordT regs [32];

    // Register 0 is never written, so it keeps its reset value of zero.
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads see the old contents during the issuing cycle.
    assign rsData  = regs[rsAddr];
    assign rtData  = regs[rtAddr];
    assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

/* sim/mipsSliceTb.sv */
// Directed testbench for the MIPS execution slice, driving it over APB against a shadow model.
`timescale 1ns/1ps
`default_nettype none

module mipsSliceTb import cpuTypesPkg::*; ();

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 8;
    // Upper bound on the APB accesses over all tests; each access takes two cycles.
    localparam int accessCount = 200;
    localparam int timeoutNs   = (accessCount * 4 + 2 * resetCycles) * clkPeriod + 1000;

    logic    CLK;
    logic    rstN;
    logic    psel;
    logic    penable;
    logic    pwrite;
    apbAddrT paddr;
    wordT    pwdata;
    wordT    prdata;
    logic    pready;
    logic    pslverr;

    wordT   shadowRegs [32];
    wordT   shadowMem [16];
    wordT   shadowPc;
    logic   shadowHalted;
    integer seed = 32'h23f4_6f48;
    int     errorCount = 0;
    int     checkCount = 0;
    string  testName = "reset";

    mipsSlice uut (
        .CLK(CLK), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the tests did not finish within %0d ns.", timeoutNs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic checkWord(input string what, input wordT expVal, input wordT actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("[ERROR] %s %s: expected %h, actual %h", testName, what, expVal, actVal);
        end
    endtask

    task automatic checkFlag(input string what, input logic expVal, input logic actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("[ERROR] %s %s: expected %b, actual %b", testName, what, expVal, actVal);
        end
    endtask

    task automatic apbAccess(input logic wr, input apbAddrT addr, input wordT data,
                             input logic expErr, output wordT rdData);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge CLK);
        penable = 1'b1;
        #2;
        rdData = prdata;
        checkFlag("pslverr", expErr, pslverr);
        checkFlag("pready", 1'b1, pready);
        @(posedge CLK);
    endtask

    task automatic apbWrite(input apbAddrT addr, input wordT data, input logic expErr);
        wordT unused;
        apbAccess(1'b1, addr, data, expErr, unused);
    endtask

    task automatic apbRead(input apbAddrT addr, output wordT data, input logic expErr);
        apbAccess(1'b0, addr, '0, expErr, data);
    endtask

    function automatic wordT rType(regBitsT rs, regBitsT rt, regBitsT rd, functT fn);
        return {RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT iType(opcodeT op, regBitsT rs, regBitsT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jType(opcodeT op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic modelReset();
        for (int i = 0; i < 32; i++) begin
            shadowRegs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            shadowMem[i] = '0;
        end
        shadowPc     = '0;
        shadowHalted = 1'b0;
    endtask

    // Architectural effect of one instruction on the shadow state.
    task automatic modelExecute(input wordT ins);
        regBitsT     rs;
        regBitsT     rt;
        regBitsT     dst;
        logic [15:0] imm;
        wordT        a;
        wordT        b;
        wordT        sImm;
        wordT        zImm;
        wordT        pc4;
        wordT        res;
        wordT        addr;
        wordT        newPc;
        logic        wr;
        rs    = ins[25:21];
        rt    = ins[20:16];
        imm   = ins[15:0];
        a     = shadowRegs[rs];
        b     = shadowRegs[rt];
        sImm  = {{16{imm[15]}}, imm};
        zImm  = {16'h0000, imm};
        addr  = a + sImm;
        pc4   = shadowPc + 32'd4;
        newPc = pc4;
        dst   = rt;
        res   = '0;
        wr    = 1'b1;
        case (ins[31:26])
            RTYPE: begin
                dst = ins[15:11];
                case (ins[5:0])
                    ADD, ADDU: res = a + b;
                    SUB, SUBU: res = a - b;
                    AND:       res = a & b;
                    OR:        res = a | b;
                    XOR:       res = a ^ b;
                    NOR:       res = ~(a | b);
                    SLT:       res = {31'd0, $signed(a) < $signed(b)};
                    SLTU:      res = {31'd0, a < b};
                    SLLV:      res = b << a[4:0];
                    SRLV:      res = b >> a[4:0];
                    JR: begin
                        wr    = 1'b0;
                        newPc = a;
                    end
                    default:   wr = 1'b0;
                endcase
            end
            ADDI, ADDIU: res = a + sImm;
            SLTI:        res = {31'd0, $signed(a) < $signed(sImm)};
            SLTIU:       res = {31'd0, a < sImm};
            ANDI:        res = a & zImm;
            ORI:         res = a | zImm;
            XORI:        res = a ^ zImm;
            LUI:         res = {imm, 16'h0000};
            LW:          res = shadowMem[addr[5:2]];
            SW: begin
                wr = 1'b0;
                shadowMem[addr[5:2]] = b;
            end
            BEQ: begin
                wr = 1'b0;
                if (a == b) newPc = pc4 + (sImm << 2);
            end
            BNE: begin
                wr = 1'b0;
                if (a != b) newPc = pc4 + (sImm << 2);
            end
            J: begin
                wr    = 1'b0;
                newPc = {pc4[31:28], ins[25:0], 2'b00};
            end
            JAL: begin
                dst   = 5'd31;
                res   = pc4;
                newPc = {pc4[31:28], ins[25:0], 2'b00};
            end
            HALT: begin
                wr           = 1'b0;
                newPc        = shadowPc;
                shadowHalted = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) shadowRegs[dst] = res;
        shadowPc = newPc;
    endtask

    task automatic checkPc();
        wordT v;
        apbRead(addrPc, v, 1'b0);
        checkWord("pc", shadowPc, v);
    endtask

    task automatic checkReg(input int n);
        wordT v;
        apbRead(addrRegBase + apbAddrT'(4 * n), v, 1'b0);
        checkWord($sformatf("r%0d", n), shadowRegs[n], v);
    endtask

    task automatic checkStatus();
        wordT v;
        apbRead(addrStatus, v, 1'b0);
        checkFlag("halted", shadowHalted, v[0]);
    endtask

    // A halted slice rejects the write, so the model only steps when it is running.
    task automatic issueInstr(input wordT ins);
        logic wasHalted;
        wasHalted = shadowHalted;
        apbWrite(addrInstr, ins, wasHalted);
        if (!wasHalted) modelExecute(ins);
        checkPc();
    endtask

    task automatic loadConst(input regBitsT r, input wordT v);
        issueInstr(iType(LUI, 5'd0, r, v[31:16]));
        issueInstr(iType(ORI, r, r, v[15:0]));
    endtask

    task automatic applyReset();
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        rstN    = 1'b0;
        repeat (resetCycles) @(negedge CLK);
        rstN = 1'b1;
        modelReset();
    endtask

    task automatic testArith();
        wordT v;
        testName = "testArith";
        for (int i = 1; i <= 4; i++) begin
            v = $random(seed);
            loadConst(regBitsT'(i), v);
        end
        v = $random(seed);
        issueInstr(iType(ADDI, 5'd0, 5'd5, v[15:0]));
        issueInstr(rType(5'd1, 5'd2, 5'd6, ADD));
        issueInstr(rType(5'd3, 5'd4, 5'd7, ADDU));
        issueInstr(rType(5'd1, 5'd2, 5'd8, SUB));
        issueInstr(rType(5'd4, 5'd3, 5'd9, SUBU));
        issueInstr(iType(ADDIU, 5'd1, 5'd10, v[31:16]));
        for (int i = 1; i <= 10; i++) begin
            checkReg(i);
        end
    endtask

    task automatic testLogicCompare();
        wordT v;
        testName = "testLogicCompare";
        v = $random(seed);
        // A negative word against a small positive one splits signed and unsigned compares.
        loadConst(5'd11, 32'h8000_0001);
        loadConst(5'd12, 32'h0000_0005);
        issueInstr(rType(5'd1, 5'd2, 5'd13, AND));
        issueInstr(rType(5'd1, 5'd2, 5'd14, OR));
        issueInstr(rType(5'd1, 5'd2, 5'd15, XOR));
        issueInstr(rType(5'd1, 5'd2, 5'd16, NOR));
        issueInstr(iType(ANDI, 5'd1, 5'd17, v[15:0] | 16'h8000));
        issueInstr(iType(XORI, 5'd2, 5'd18, v[31:16]));
        issueInstr(rType(5'd11, 5'd12, 5'd19, SLT));
        issueInstr(rType(5'd11, 5'd12, 5'd20, SLTU));
        issueInstr(iType(SLTI, 5'd12, 5'd21, 16'hffff));
        issueInstr(iType(SLTIU, 5'd12, 5'd22, 16'hffff));
        issueInstr(rType(5'd12, 5'd1, 5'd23, SLLV));
        issueInstr(rType(5'd12, 5'd1, 5'd24, SRLV));
        for (int i = 13; i <= 24; i++) begin
            checkReg(i);
        end
    endtask

    task automatic testMemory();
        testName = "testMemory";
        issueInstr(iType(ORI, 5'd0, 5'd25, 16'h0040));
        issueInstr(iType(SW, 5'd25, 5'd1, 16'h0000));
        issueInstr(iType(SW, 5'd25, 5'd2, 16'h0004));
        issueInstr(iType(SW, 5'd25, 5'd3, 16'h000c));
        issueInstr(iType(SW, 5'd25, 5'd4, 16'hfffc));
        // Offsets 64 bytes higher alias the same words in the 16-word memory.
        issueInstr(iType(LW, 5'd25, 5'd26, 16'h0040));
        issueInstr(iType(LW, 5'd25, 5'd27, 16'h0044));
        issueInstr(iType(LW, 5'd25, 5'd28, 16'h004c));
        issueInstr(iType(LW, 5'd25, 5'd29, 16'h003c));
        for (int i = 26; i <= 29; i++) begin
            checkReg(i);
        end
    endtask

    task automatic testControlFlow();
        wordT v;
        testName = "testControlFlow";
        apbWrite(addrPc, 32'h0000_0100, 1'b0);
        shadowPc = 32'h0000_0100;
        checkPc();
        issueInstr(iType(BEQ, 5'd11, 5'd11, 16'h0006));
        issueInstr(iType(BEQ, 5'd11, 5'd12, 16'h0006));
        issueInstr(iType(BNE, 5'd11, 5'd12, 16'hfffc));
        issueInstr(iType(BNE, 5'd12, 5'd12, 16'h0010));
        v = $random(seed);
        issueInstr(jType(J, v[25:0]));
        v = $random(seed);
        issueInstr(jType(JAL, v[25:0]));
        checkReg(31);
        v = $random(seed);
        loadConst(5'd30, v & 32'hffff_fffc);
        issueInstr(rType(5'd30, 5'd0, 5'd9, JR));
        checkReg(9);
        checkReg(31);
    endtask

    task automatic testRegZero();
        wordT v;
        testName = "testRegZero";
        issueInstr(iType(ADDI, 5'd1, 5'd0, 16'h1234));
        issueInstr(iType(LUI, 5'd0, 5'd0, 16'habcd));
        issueInstr(rType(5'd1, 5'd2, 5'd0, ADD));
        issueInstr({6'b010000, 26'h3ff_ffff});
        checkReg(0);
        apbRead(8'h40, v, 1'b1);
        apbRead(8'h81, v, 1'b1);
        apbWrite(addrStatus, 32'h1, 1'b1);
        apbWrite(addrRegBase + 8'h04, 32'h1, 1'b1);
        checkPc();
    endtask

    task automatic testHalt();
        testName = "testHalt";
        issueInstr({HALT, 26'd0});
        checkStatus();
        issueInstr(iType(ADDI, 5'd5, 5'd5, 16'h0001));
        checkReg(5);
        applyReset();
        checkPc();
        checkStatus();
        checkReg(5);
    endtask

    initial begin
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        modelReset();
        repeat (resetCycles) @(negedge CLK);
        rstN = 1'b1;
        testArith();
        testLogicCompare();
        testMemory();
        testControlFlow();
        testRegZero();
        testHalt();
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
